// File: design/mem_params.svh
// sizing for the memory stage
// NUM_SETS must equal 2**IDX_BITS, the index is taken straight from the address
// one 64-bit word per line, so the low 3 address bits never reach the cache
// a bus tag of zero means "no transaction", so at most 2**MEM_TAG_BITS-1 in flight

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////////////////////

`define NUM_SETS          16   // direct mapped, one line per set
`define IDX_BITS          4    // log2 of NUM_SETS
`define WORD_OFFSET_BITS  3    // byte within the 64-bit word, ignored

// whatever is left of the 64-bit address above index and offset
`define CACHE_TAG_BITS    (64 - `IDX_BITS - `WORD_OFFSET_BITS)

////////////////////////////////////////////////////////////////////////////
// retire buffer and memory bus
////////////////////////////////////////////////////////////////////////////

`define RETIRE_SIZE       4    // dirty victims waiting for write-back
`define MEM_TAG_BITS      4    // width of response and data tag buses

`endif

// File: design/mem_pkg.sv
// types shared by the cache, the retire buffer and the stage top
// bus command codes follow the memory model: none, load, store
// addresses are byte addresses of 64-bit words, offset bits are don't-care

`include "mem_params.svh"

package mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // memory bus
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,  // idle cycle
    BUS_LOAD  = 2'h1,  // read one word, data comes back on the tag bus
    BUS_STORE = 2'h2   // write one word, done on acceptance
  } bus_cmd_e;

  ////////////////////////////////////////////////////////////////////////////
  // cache address, seen either as a plain word or split for lookup
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0]   tag;     // compared against the line tag
    logic [`IDX_BITS-1:0]         idx;     // selects the set
    logic [`WORD_OFFSET_BITS-1:0] offset;  // byte in word, unused
  } dcache_addr_t;

  typedef union packed {
    logic [63:0]  word;    // raw address as the pipeline hands it over
    dcache_addr_t fields;  // lookup view
  } dcache_addr_u;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // one cache line, 123 bits
  typedef struct packed {
    logic                       valid;
    logic                       dirty;  // differs from memory, write back on eviction
    logic [`CACHE_TAG_BITS-1:0] tag;
    logic [63:0]                data;
  } cache_line_t;

  // evicted line, line-aligned address plus data
  // also the push payload from cache to buffer
  typedef struct packed {
    logic [63:0] addr;
    logic [63:0] data;
  } retire_entry_t;

endpackage

// File: design/dcache.sv
// direct-mapped write-back data cache, one 64-bit word per line
// the caller never raises rd_en and wr_en together, and holds a missing load
// steady until rd_valid comes back
// stores are only issued while the retire buffer has room (ret_full low)
// the Dmem port carries loads only; dirty data leaves through the retire buffer
// one miss outstanding at a time, response tag zero means not accepted

`include "mem_params.svh"

module dcache import mem_pkg::*; (
  input  logic                     clock,
  input  logic                     rst,
  // load request
  input  logic                     rd_en,
  input  dcache_addr_u             rd_addr,
  // store request, single cycle
  input  logic                     wr_en,
  input  dcache_addr_u             wr_addr,
  input  logic [63:0]              wr_data,
  // data memory responses
  input  logic [`MEM_TAG_BITS-1:0] Dmem2proc_response,
  input  logic [63:0]              Dmem2proc_data,
  input  logic [`MEM_TAG_BITS-1:0] Dmem2proc_tag,
  // answers from the retire buffer
  input  logic                     fwd_hit,
  input  logic [63:0]              fwd_data,
  input  logic                     ret_full,
  // load result
  output logic [63:0]              rd_data,
  output logic                     rd_valid,
  // miss completion strobe
  output logic [63:0]              miss_addr,
  output logic [63:0]              miss_data,
  output logic                     miss_valid,
  // data memory command
  output bus_cmd_e                 proc2Dmem_command,
  output logic [63:0]              proc2Dmem_addr,
  output logic [63:0]              proc2Dmem_data,
  // retire buffer side
  output logic [63:0]              fwd_addr,
  output retire_entry_t            victim,
  output logic                     victim_valid
);

  typedef enum logic [1:0] {
    MS_IDLE,    // no miss in flight
    MS_ACCEPT,  // load command held, waiting for a nonzero response
    MS_DATA     // accepted, waiting for our tag on the data bus
  } miss_state_e;

  cache_line_t              lines [`NUM_SETS];
  miss_state_e              state, state_nxt;
  logic [`MEM_TAG_BITS-1:0] miss_tag;  // tag handed out on acceptance

  cache_line_t rd_line, wr_line;       // lines under the two indexes
  logic [63:0] rd_line_addr;           // load address, word aligned
  logic        rd_hit, rd_miss;
  logic        need_evict;             // fill would displace a dirty line
  logic        evict_ok;               // ...and the buffer can take it
  logic        fwd_fill, mem_fill, fill_now;
  logic [63:0] fill_data;
  logic        load_req, load_accept;
  logic        wr_evict;

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////

  assign rd_line = lines[rd_addr.fields.idx];
  assign wr_line = lines[wr_addr.fields.idx];

  assign rd_line_addr = {rd_addr.fields.tag, rd_addr.fields.idx,
                         {`WORD_OFFSET_BITS{1'b0}}};

  assign rd_hit  = rd_en && rd_line.valid && (rd_line.tag == rd_addr.fields.tag);
  assign rd_miss = rd_en && !rd_hit;

  // on a miss a valid line always has another tag, dirty means write back
  assign need_evict = rd_line.valid && rd_line.dirty;
  assign evict_ok   = !need_evict || !ret_full;  // full buffer holds the miss in idle

  ////////////////////////////////////////////////////////////////////////////
  // miss handling
  ////////////////////////////////////////////////////////////////////////////

  // pending victim in the buffer wins over memory, filled at the next edge
  assign fwd_fill = (state == MS_IDLE) && rd_miss && evict_ok && fwd_hit;

  // command goes out already in the miss cycle, held until accepted
  assign load_req = ((state == MS_IDLE) && rd_miss && evict_ok && !fwd_hit) ||
                    (state == MS_ACCEPT);
  assign load_accept = load_req && (Dmem2proc_response != '0);

  assign mem_fill  = (state == MS_DATA) && (Dmem2proc_tag == miss_tag);
  assign fill_now  = fwd_fill || mem_fill;
  assign fill_data = mem_fill ? Dmem2proc_data : fwd_data;

  always_comb begin
    state_nxt = state;
    case (state)
      MS_IDLE: begin
        if (load_req) begin
          state_nxt = load_accept ? MS_DATA : MS_ACCEPT;
        end
      end
      MS_ACCEPT: begin
        if (load_accept) state_nxt = MS_DATA;
      end
      MS_DATA: begin
        if (mem_fill) state_nxt = MS_IDLE;  // line written at this edge
      end
      default: state_nxt = MS_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state    <= MS_IDLE;
      miss_tag <= '0;
    end else begin
      state <= state_nxt;
      if (load_accept) miss_tag <= Dmem2proc_response;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  // memory data passes straight through in the fill cycle, stall drops there
  assign rd_valid = rd_hit || mem_fill;
  assign rd_data  = mem_fill ? Dmem2proc_data : rd_line.data;

  assign miss_valid = mem_fill;      // one cycle per completed memory miss
  assign miss_addr  = rd_addr.word;  // held by the caller during the miss
  assign miss_data  = Dmem2proc_data;

  assign proc2Dmem_command = load_req ? BUS_LOAD : BUS_NONE;
  assign proc2Dmem_addr    = rd_line_addr;
  assign proc2Dmem_data    = '0;     // loads carry no data

  assign fwd_addr = rd_line_addr;    // buffer entries are word aligned too

  ////////////////////////////////////////////////////////////////////////////
  // victim push
  ////////////////////////////////////////////////////////////////////////////

  // store over a dirty line of another tag
  assign wr_evict = wr_en && wr_line.valid && wr_line.dirty &&
                    (wr_line.tag != wr_addr.fields.tag);

  assign victim_valid = wr_evict || (fill_now && need_evict);

  always_comb begin
    if (wr_en) begin
      victim.addr = {wr_line.tag, wr_addr.fields.idx, {`WORD_OFFSET_BITS{1'b0}}};
      victim.data = wr_line.data;
    end else begin
      victim.addr = {rd_line.tag, rd_addr.fields.idx, {`WORD_OFFSET_BITS{1'b0}}};
      victim.data = rd_line.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // line array
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < `NUM_SETS; i++) begin
        lines[i].valid <= 1'b0;  // tag and data keep whatever they had
        lines[i].dirty <= 1'b0;
      end
    end else if (wr_en) begin
      // write allocate, whole word so no fetch needed
      lines[wr_addr.fields.idx] <= cache_line_t'{valid: 1'b1, dirty: 1'b1,
                                                 tag: wr_addr.fields.tag,
                                                 data: wr_data};
    end else if (fill_now) begin
      lines[rd_addr.fields.idx] <= cache_line_t'{valid: 1'b1, dirty: 1'b0,
                                                 tag: rd_addr.fields.tag,
                                                 data: fill_data};
    end
  end

endmodule

// File: design/retire_buffer.sv
// FIFO of dirty lines evicted from the data cache, written back over Rmem
// one push per cycle; the cache only pushes while full is low
// a push and a pop may share a cycle, a push while full is dropped
// forward lookup is combinational and picks the newest matching entry

`include "mem_params.svh"

module retire_buffer import mem_pkg::*; #(
  parameter int DEPTH = `RETIRE_SIZE
) (
  input  logic                     clock,
  input  logic                     rst,
  // push from the cache
  input  retire_entry_t            victim,
  input  logic                     victim_valid,
  // forward lookup
  input  logic [63:0]              fwd_addr,
  output logic                     fwd_hit,
  output logic [63:0]              fwd_data,
  // write-back port
  input  logic [`MEM_TAG_BITS-1:0] Rmem2proc_response,
  output logic                     full,
  output bus_cmd_e                 proc2Rmem_command,
  output logic [63:0]              proc2Rmem_addr,
  output logic [63:0]              proc2Rmem_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  retire_entry_t       entries [DEPTH];
  logic [PTR_BITS-1:0] head;   // oldest entry, next to write back
  logic [PTR_BITS-1:0] tail;   // next free slot
  logic [PTR_BITS:0]   count;  // 0..DEPTH
  logic                empty;
  logic                push, pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    if (p == PTR_BITS'(DEPTH - 1)) return '0;
    return p + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // occupancy
  ////////////////////////////////////////////////////////////////////////////

  assign empty = (count == '0);
  assign full  = (count == (PTR_BITS + 1)'(DEPTH));

  assign push = victim_valid && !full;
  assign pop  = !empty && (Rmem2proc_response != '0);  // store accepted

  always_ff @(posedge clock) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= ptr_inc(tail);
      if (pop) head <= ptr_inc(head);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // payload only, slots past count are never looked at
  always_ff @(posedge clock) begin
    if (push) entries[tail] <= victim;
  end

  ////////////////////////////////////////////////////////////////////////////
  // write-back driver
  ////////////////////////////////////////////////////////////////////////////

  // head stays on the bus until the memory takes it
  assign proc2Rmem_command = empty ? BUS_NONE : BUS_STORE;
  assign proc2Rmem_addr    = entries[head].addr;
  assign proc2Rmem_data    = entries[head].data;

  ////////////////////////////////////////////////////////////////////////////
  // forward search
  ////////////////////////////////////////////////////////////////////////////

  // walk back from tail so that a line evicted twice gives its latest data
  always_comb begin
    int slot;
    fwd_hit  = 1'b0;
    fwd_data = '0;
    for (int k = 0; k < DEPTH; k++) begin
      slot = (int'(tail) + 2 * DEPTH - 1 - k) % DEPTH;  // k-th newest
      if (!fwd_hit && (k < int'(count)) && (entries[slot].addr == fwd_addr)) begin
        fwd_hit  = 1'b1;
        fwd_data = entries[slot].data;
      end
    end
  end

endmodule

// File: design/mem_stage.sv
// memory access stage of the load/store path, cache plus retire buffer
// the caller never raises rd_mem and wr_mem together, holds a load while
// mem_rd_stall is high and issues nothing while mem_stall_out is high
// no store-queue forwarding here, every load goes to the cache
// Dmem carries cache fills, Rmem carries write-backs of dirty victims

`include "mem_params.svh"

module mem_stage import mem_pkg::*; (
  input  logic                     clock,
  input  logic                     rst,
  // requests from the pipeline
  input  logic                     rd_mem,
  input  logic [63:0]              rd_addr,
  input  logic                     wr_mem,
  input  logic [63:0]              wr_addr,
  input  logic [63:0]              wr_data,
  // memory responses
  input  logic [63:0]              Dmem2proc_data,
  input  logic [`MEM_TAG_BITS-1:0] Dmem2proc_tag,
  input  logic [`MEM_TAG_BITS-1:0] Dmem2proc_response,
  input  logic [`MEM_TAG_BITS-1:0] Rmem2proc_response,
  // results and stalls
  output logic [63:0]              mem_result_out,
  output logic                     mem_rd_stall,
  output logic                     mem_stall_out,
  output logic [63:0]              mem_rd_miss_addr_out,
  output logic [63:0]              mem_rd_miss_data_out,
  output logic                     mem_rd_miss_valid_out,
  // memory commands
  output bus_cmd_e                 proc2Dmem_command,
  output logic [63:0]              proc2Dmem_addr,
  output logic [63:0]              proc2Dmem_data,
  output bus_cmd_e                 proc2Rmem_command,
  output logic [63:0]              proc2Rmem_addr,
  output logic [63:0]              proc2Rmem_data
);

  logic [63:0]   dcache_data;
  logic          dcache_valid;
  logic          ret_full;
  retire_entry_t victim;         // cache -> buffer push
  logic          victim_valid;
  logic [63:0]   fwd_addr;       // miss lookup into the buffer
  logic [63:0]   fwd_data;
  logic          fwd_hit;

  // non-load ops pass the address on, same as the older pipeline did
  assign mem_result_out = rd_mem ? dcache_data : rd_addr;
  assign mem_rd_stall   = rd_mem && !dcache_valid;
  assign mem_stall_out  = ret_full;  // no room for another dirty victim

  dcache dcache_inst (
    .clock              (clock),
    .rst                (rst),
    .rd_en              (rd_mem),
    .rd_addr            (rd_addr),
    .wr_en              (wr_mem),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .Dmem2proc_response (Dmem2proc_response),
    .Dmem2proc_data     (Dmem2proc_data),
    .Dmem2proc_tag      (Dmem2proc_tag),
    .fwd_hit            (fwd_hit),
    .fwd_data           (fwd_data),
    .ret_full           (ret_full),
    .rd_data            (dcache_data),
    .rd_valid           (dcache_valid),
    .miss_addr          (mem_rd_miss_addr_out),
    .miss_data          (mem_rd_miss_data_out),
    .miss_valid         (mem_rd_miss_valid_out),
    .proc2Dmem_command  (proc2Dmem_command),
    .proc2Dmem_addr     (proc2Dmem_addr),
    .proc2Dmem_data     (proc2Dmem_data),
    .fwd_addr           (fwd_addr),
    .victim             (victim),
    .victim_valid       (victim_valid)
  );

  retire_buffer #(
    .DEPTH (`RETIRE_SIZE)
  ) retire_inst (
    .clock              (clock),
    .rst                (rst),
    .victim             (victim),
    .victim_valid       (victim_valid),
    .fwd_addr           (fwd_addr),
    .fwd_hit            (fwd_hit),
    .fwd_data           (fwd_data),
    .Rmem2proc_response (Rmem2proc_response),
    .full               (ret_full),
    .proc2Rmem_command  (proc2Rmem_command),
    .proc2Rmem_addr     (proc2Rmem_addr),
    .proc2Rmem_data     (proc2Rmem_data)
  );

endmodule

// File: tests/tb_mem_model.sv
// behavioral memory behind both bus ports of mem_stage
// words never written read back as a hash of their word address
// busy cycles come from a Galois LFSR, hold_rmem keeps Rmem busy
// load data returns with its tag in the third cycle after acceptance
// peek_data shows a word one edge after peek_addr is set

`include "mem_params.svh"

module tb_mem_model import mem_pkg::*; (
  input  logic                     clock,
  input  logic                     rst,
  input  bus_cmd_e                 proc2Dmem_command,
  input  logic [63:0]              proc2Dmem_addr,
  output logic [`MEM_TAG_BITS-1:0] Dmem2proc_response,
  output logic [63:0]              Dmem2proc_data,
  output logic [`MEM_TAG_BITS-1:0] Dmem2proc_tag,
  input  bus_cmd_e                 proc2Rmem_command,
  input  logic [63:0]              proc2Rmem_addr,
  input  logic [63:0]              proc2Rmem_data,
  output logic [`MEM_TAG_BITS-1:0] Rmem2proc_response,
  input  logic                     hold_rmem,   // force Rmem busy
  input  logic [63:0]              peek_addr,
  output logic [63:0]              peek_data
);

  typedef struct packed {
    logic [`MEM_TAG_BITS-1:0] tag;
    logic [63:0]              data;
    logic [31:0]              due;   // cycle count at which it goes on the bus
  } load_return_t;

  logic [63:0]              words [logic [63:0]];  // sparse, only written words
  load_return_t             pending [$];
  logic [`MEM_TAG_BITS-1:0] next_tag;               // never zero
  logic [31:0]              cycle;
  logic [31:0]              lfsr = 32'h18b9;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [63:0] seed_word(input logic [63:0] a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]} ^ 64'h5a5a_3c3c_0f0f_9696;
  endfunction

  function automatic logic [63:0] read_word(input logic [63:0] a);
    logic [63:0] w;
    w = {a[63:3], 3'b000};
    if (words.exists(w)) return words[w];
    return seed_word(w);
  endfunction

  always @(posedge clock) begin
    if (rst) begin
      Dmem2proc_response <= '0;
      Dmem2proc_data     <= '0;
      Dmem2proc_tag      <= '0;
      Rmem2proc_response <= '0;
      peek_data          <= '0;
      next_tag = 1;
      cycle    = 0;
      pending.delete();
    end else begin
      cycle = cycle + 1;
      // writes first, so a load accepted at the same edge sees them
      if (proc2Rmem_command == BUS_STORE && Rmem2proc_response != '0)
        words[{proc2Rmem_addr[63:3], 3'b000}] = proc2Rmem_data;
      if (proc2Dmem_command == BUS_LOAD && Dmem2proc_response != '0) begin
        pending.push_back(load_return_t'{tag: Dmem2proc_response,
                                         data: read_word(proc2Dmem_addr),
                                         due: cycle + 2});
        next_tag = (next_tag == '1) ? 1 : next_tag + 1'b1;
      end
      if (pending.size() != 0 && pending[0].due == cycle) begin
        Dmem2proc_tag  <= pending[0].tag;
        Dmem2proc_data <= pending[0].data;
        void'(pending.pop_front());
      end else begin
        Dmem2proc_tag <= '0;   // zero tag, nothing on the data bus
      end
      // one cycle in four is busy on each port
      Dmem2proc_response <= (take_bits(2) != 0) ? next_tag : '0;
      Rmem2proc_response <= (take_bits(2) == 0 || hold_rmem) ? '0 : `MEM_TAG_BITS'(1);
      peek_data          <= read_word(peek_addr);
    end
  end

endmodule

// File: tests/mem_stage_tb.sv
// testbench for mem_stage, directed cases then a random load/store mix
// inputs change on the rising edge, outputs are sampled at the next one
// the caller leaves an idle cycle after each op so stall flags are current
// all addresses are word aligned, offset bits are never exercised

`include "mem_params.svh"

module mem_stage_tb import mem_pkg::*; ();

  localparam int          WAIT_LIMIT = 200;                 // cycles per wait
  localparam int          MIX_OPS    = 400;
  localparam logic [63:0] BP_BASE    = 64'h0000_0000_0001_0048;  // set 9
  localparam logic [63:0] MIX_BASE   = 64'h0000_0000_0004_0000;

  logic                     clock;
  logic                     rst;
  logic                     rd_mem, wr_mem;
  logic [63:0]              rd_addr, wr_addr, wr_data;
  logic [63:0]              Dmem2proc_data;
  logic [`MEM_TAG_BITS-1:0] Dmem2proc_tag, Dmem2proc_response, Rmem2proc_response;
  logic [63:0]              mem_result_out;
  logic                     mem_rd_stall, mem_stall_out;
  logic [63:0]              mem_rd_miss_addr_out, mem_rd_miss_data_out;
  logic                     mem_rd_miss_valid_out;
  bus_cmd_e                 proc2Dmem_command, proc2Rmem_command;
  logic [63:0]              proc2Dmem_addr, proc2Dmem_data;
  logic [63:0]              proc2Rmem_addr, proc2Rmem_data;
  logic                     hold_rmem;
  logic [63:0]              peek_addr, peek_data;

  logic [63:0] ref_words [logic [63:0]];  // architectural view, stores only
  logic [31:0] lfsr_state    = 32'h18b9;
  int          loads_checked = 0;
  int          misses_seen   = 0;

  mem_stage    mem_stage_inst (.*);
  tb_mem_model mem_model_inst (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [63:0] word_addr(input logic [63:0] a);
    return {a[63:3], 3'b000};
  endfunction

  // contents of a word never stored
  function automatic logic [63:0] seed_word(input logic [63:0] a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]} ^ 64'h5a5a_3c3c_0f0f_9696;
  endfunction

  // last store wins, else the seed value
  function automatic logic [63:0] expected_word(input logic [63:0] a);
    if (ref_words.exists(word_addr(a))) return ref_words[word_addr(a)];
    return seed_word(word_addr(a));
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] got);
    assert (got === exp_v) else
      stop_on_error($sformatf("ERR t=%0t %s expected %h got %h",
                              $time, name, exp_v, got));
  endtask

  task automatic wait_stall_clear();
    int n;
    n = 0;
    while (mem_stall_out !== 1'b0) begin
      if (n >= WAIT_LIMIT) stop_on_error("timeout, mem_stall_out never went low");
      else begin
        n++;
        @(posedge clock);
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (proc2Rmem_command !== BUS_NONE) begin
      if (n >= WAIT_LIMIT) stop_on_error("timeout, retire buffer never drained");
      else begin
        n++;
        @(posedge clock);
      end
    end
  endtask

  task automatic issue_store(input logic [63:0] a, input logic [63:0] d);
    wait_stall_clear();
    wr_mem  <= 1'b1;
    wr_addr <= a;
    wr_data <= d;
    @(posedge clock);
    wr_mem <= 1'b0;
    @(posedge clock);   // idle cycle
  endtask

  // returns the number of stalled cycles
  task automatic issue_load(input logic [63:0] a, output int stalls);
    wait_stall_clear();
    rd_mem  <= 1'b1;
    rd_addr <= a;
    stalls = 0;
    @(posedge clock);
    while (mem_rd_stall !== 1'b0) begin
      if (stalls >= WAIT_LIMIT) stop_on_error("timeout, load never completed");
      else begin
        stalls++;
        @(posedge clock);
      end
    end
    rd_mem <= 1'b0;
    @(posedge clock);
  endtask

  task automatic peek_memory(input logic [63:0] a, output logic [63:0] d);
    peek_addr <= a;
    @(posedge clock);
    @(posedge clock);   // model registers the read
    d = peek_data;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare process, owns the reference memory
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (!rst) begin
      if (rd_mem && !mem_rd_stall) begin
        check_value("mem_result_out", expected_word(rd_addr), mem_result_out);
        loads_checked++;
      end
      if (!rd_mem) check_value("mem_result_out", rd_addr, mem_result_out);  // address passes
      if (mem_rd_miss_valid_out) begin
        check_value("mem_rd_miss_addr_out", rd_addr, mem_rd_miss_addr_out);
        check_value("mem_rd_miss_data_out", expected_word(rd_addr), mem_rd_miss_data_out);
        misses_seen++;
      end
      // fill request asks for the word under the held load
      if (proc2Dmem_command == BUS_LOAD) begin
        check_value("proc2Dmem_addr", word_addr(rd_addr), proc2Dmem_addr);
        check_value("proc2Dmem_data", 64'h0, proc2Dmem_data);
      end
      if (wr_mem) ref_words[word_addr(wr_addr)] = wr_data;  // lands at this edge
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [63:0] a, d;
    int          stalls, m0, n0;
    rst = 1'b1;
    rd_mem = 1'b0;
    wr_mem = 1'b0;
    rd_addr = '0;
    wr_addr = '0;
    wr_data = '0;
    hold_rmem = 1'b0;
    peek_addr = '0;
    repeat (2) @(posedge clock);
    rst <= 1'b0;
    @(posedge clock);

    // reset values, first cycle out of reset
    check_value("proc2Dmem_command", BUS_NONE, proc2Dmem_command);
    check_value("proc2Rmem_command", BUS_NONE, proc2Rmem_command);
    check_value("mem_rd_stall", 0, mem_rd_stall);
    check_value("mem_stall_out", 0, mem_stall_out);
    check_value("mem_rd_miss_valid_out", 0, mem_rd_miss_valid_out);

    // cold load, must go to memory
    m0 = misses_seen;
    issue_load(64'h0000_0000_0000_1008, stalls);
    assert (stalls > 0) else stop_on_error("cold load returned without a stall");
    check_value("miss strobe count", m0 + 1, misses_seen);

    // store then hit
    issue_store(64'h0000_0000_0000_2010, 64'h1111_2222_3333_4444);
    issue_load(64'h0000_0000_0000_2010, stalls);
    check_value("mem_rd_stall cycles", 0, stalls);

    // conflict eviction in set 3
    issue_store(64'h0000_0000_0000_3018, 64'haaaa_0000_aaaa_0001);
    issue_store(64'h0000_0000_0000_5018, 64'hbbbb_0000_bbbb_0002);  // evicts A
    issue_load(64'h0000_0000_0000_3018, stalls);
    wait_drain();
    peek_memory(64'h0000_0000_0000_3018, d);
    check_value("memory word A", 64'haaaa_0000_aaaa_0001, d);

    // back-pressure, write-backs held off
    hold_rmem <= 1'b1;
    repeat (2) @(posedge clock);
    for (int i = 0; i <= `RETIRE_SIZE; i++) begin
      issue_store(BP_BASE + 64'(i) * 64'h80, 64'hb000_0000_0000_0000 | 64'(i));
      check_value("mem_stall_out", (i == `RETIRE_SIZE), mem_stall_out);
    end
    hold_rmem <= 1'b0;
    wait_stall_clear();
    wait_drain();
    peek_memory(BP_BASE, d);
    check_value("memory word set 9", 64'hb000_0000_0000_0000, d);
    for (int i = 0; i <= `RETIRE_SIZE; i++) issue_load(BP_BASE + 64'(i) * 64'h80, stalls);

    // random mix over 64 words, 4 tags per set
    n0 = loads_checked;
    for (int i = 0; i < MIX_OPS; i++) begin
      a = MIX_BASE + (take_bits(6) << 3);
      if (take_bits(1) == 1) begin
        d = take_bits(64);
        issue_store(a, d);
      end else begin
        issue_load(a, stalls);
      end
    end
    for (int k = 0; k < 64; k++) issue_load(MIX_BASE + 64'(k) * 64'h8, stalls);
    assert (loads_checked > n0 + 64) else stop_on_error("random mix checked too few loads");

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - design

sources:
  - design/mem_pkg.sv
  - design/dcache.sv
  - design/retire_buffer.sv
  - design/mem_stage.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/mem_stage_tb.sv

// File: all.f
+incdir+design
design/mem_pkg.sv
design/dcache.sv
design/retire_buffer.sv
design/mem_stage.sv
tests/tb_mem_model.sv
tests/mem_stage_tb.sv
